//--- source/orbit_pkg.sv
package orbit_pkg;

    ////////////////////
    // Fixed-point geometry
    ////////////////////

    // 256 steps per full turn
    typedef logic [7:0] angle_t;

    // Signed trig value, full scale 16'h3fff
    typedef logic signed [15:0] trig_t;

    typedef logic [15:0] radius_t;
    typedef logic [31:0] coord_t;

    // Active-low seven-segment pattern, bit 0 is segment a
    typedef logic [6:0] glyph_t;

    // Right shift applied after trig * radius
    localparam int TRIG_FRAC_BITS = 14;

    ////////////////////
    // Reset defaults
    ////////////////////

    localparam coord_t  RESET_CENTER_X = 32'h00008000;
    localparam coord_t  RESET_CENTER_Y = 32'h00008000;
    localparam radius_t RESET_RADIUS   = 16'h4000;
    localparam angle_t  RESET_STEP     = 8'd1;

    ////////////////////
    // Quarter-wave sine
    ////////////////////

    // Sine for angles 0 to 64 inclusive
    // Remaining quadrants come from mirroring and negation
    localparam trig_t QUARTER_SINE [65] = '{
        16'h0000, 16'h0192, 16'h0323, 16'h04b5, 16'h0645, 16'h07d5, 16'h0963, 16'h0af0,
        16'h0c7c, 16'h0e05, 16'h0f8c, 16'h1111, 16'h1293, 16'h1413, 16'h158f, 16'h1708,
        16'h187d, 16'h19ef, 16'h1b5c, 16'h1cc5, 16'h1e2a, 16'h1f8b, 16'h20e6, 16'h223c,
        16'h238d, 16'h24d9, 16'h261f, 16'h275f, 16'h2899, 16'h29cc, 16'h2afa, 16'h2c20,
        16'h2d40, 16'h2e59, 16'h2f6b, 16'h3075, 16'h3178, 16'h3273, 16'h3366, 16'h3452,
        16'h3535, 16'h3611, 16'h36e4, 16'h37ae, 16'h3870, 16'h3929, 16'h39da, 16'h3a81,
        16'h3b1f, 16'h3bb5, 16'h3c41, 16'h3cc4, 16'h3d3d, 16'h3dad, 16'h3e14, 16'h3e70,
        16'h3ec4, 16'h3f0d, 16'h3f4d, 16'h3f83, 16'h3fb0, 16'h3fd2, 16'h3feb, 16'h3ffa,
        16'h3fff
    };

    ////////////////////
    // Seven-segment glyphs
    ////////////////////

    // Hex digits 0 to F, segment order gfedcba, low means lit
    localparam glyph_t SEG_GLYPHS [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

//--- source/apb_map_pkg.sv
package apb_map_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    ////////////////////
    // Register offsets
    ////////////////////

    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STEP     = 8'h04;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_RADIUS   = 8'h08;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CENTER_X = 8'h0C;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CENTER_Y = 8'h10;
    // Only writable while the orbit is stopped
    localparam logic [APB_ADDR_WIDTH-1:0] REG_ANGLE    = 8'h14;
    // Read-only positions
    localparam logic [APB_ADDR_WIDTH-1:0] REG_POS_X    = 8'h18;
    localparam logic [APB_ADDR_WIDTH-1:0] REG_POS_Y    = 8'h1C;

    // Fields of REG_CTRL
    localparam int CTRL_RUN_BIT = 0;
    localparam int CTRL_SEL_BIT = 1;

endpackage

//--- source/orbit_ctrl.sv
`timescale 1ns/10ps

module orbit_ctrl (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [apb_map_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [apb_map_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [apb_map_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    input  orbit_pkg::coord_t                      pos_x,
    input  orbit_pkg::coord_t                      pos_y,
    output orbit_pkg::angle_t                      angle,
    output orbit_pkg::radius_t                     radius,
    output orbit_pkg::coord_t                      center_x,
    output orbit_pkg::coord_t                      center_y,
    output logic                                   disp_sel
);
    import orbit_pkg::*;
    import apb_map_pkg::*;

    logic                      run;
    angle_t                    step;
    logic                      access;
    logic                      mapped;
    logic                      write_err;
    logic                      wr_en;
    logic [APB_DATA_WIDTH-1:0] rd_data;

    ////////////////////
    // APB decode
    ////////////////////

    // Slave never stalls so every access cycle completes
    assign access = psel && penable;
    assign pready = access;

    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (paddr)
            REG_CTRL: begin
                rd_data[CTRL_RUN_BIT] = run;
                rd_data[CTRL_SEL_BIT] = disp_sel;
            end
            REG_STEP:     rd_data = APB_DATA_WIDTH'(step);
            REG_RADIUS:   rd_data = APB_DATA_WIDTH'(radius);
            REG_CENTER_X: rd_data = APB_DATA_WIDTH'(center_x);
            REG_CENTER_Y: rd_data = APB_DATA_WIDTH'(center_y);
            REG_ANGLE:    rd_data = APB_DATA_WIDTH'(angle);
            REG_POS_X:    rd_data = APB_DATA_WIDTH'(pos_x);
            REG_POS_Y:    rd_data = APB_DATA_WIDTH'(pos_y);
            default:      mapped  = 1'b0;
        endcase
    end

    // Positions are read-only, angle is locked while running
    assign write_err = pwrite && ((paddr == REG_POS_X) || (paddr == REG_POS_Y) ||
                                  ((paddr == REG_ANGLE) && run));

    assign pslverr = access && (!mapped || write_err);
    assign wr_en   = access && pwrite && mapped && !write_err;
    assign prdata  = (access && !pwrite) ? rd_data : '0;

    ////////////////////
    // Configuration registers
    ////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run      <= 1'b0;
            disp_sel <= 1'b0;
            step     <= RESET_STEP;
            radius   <= RESET_RADIUS;
            center_x <= RESET_CENTER_X;
            center_y <= RESET_CENTER_Y;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL: begin
                    run      <= pwdata[CTRL_RUN_BIT];
                    disp_sel <= pwdata[CTRL_SEL_BIT];
                end
                REG_STEP:     step     <= pwdata[$bits(angle_t)-1:0];
                REG_RADIUS:   radius   <= pwdata[$bits(radius_t)-1:0];
                REG_CENTER_X: center_x <= pwdata[$bits(coord_t)-1:0];
                REG_CENTER_Y: center_y <= pwdata[$bits(coord_t)-1:0];
                default: begin
                end
            endcase
        end
    end

    ////////////////////
    // Phase accumulator
    ////////////////////

    // Wraps modulo 256 by width
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            angle <= '0;
        end else if (wr_en && (paddr == REG_ANGLE)) begin
            angle <= pwdata[$bits(angle_t)-1:0];
        end else if (run) begin
            angle <= angle + step;
        end
    end

    ////////////////////
    // Bus protocol checks
    ////////////////////

    // Access phase must follow a selected setup phase
    assert property (@(posedge clk) disable iff (reset) $rose(penable) |-> psel)
        else $error("APB penable asserted without psel");

    // Address held from setup into access
    assert property (@(posedge clk) disable iff (reset)
                     (psel && !penable) ##1 (psel && penable) |-> $stable(paddr))
        else $error("APB paddr changed during access cycle");

endmodule

//--- source/trig_lut.sv
`timescale 1ns/10ps

module trig_lut (
    input  logic              clk,
    input  logic              reset,
    input  orbit_pkg::angle_t angle,
    output orbit_pkg::trig_t  sin_val,
    output orbit_pkg::trig_t  cos_val
);
    import orbit_pkg::*;

    angle_t cos_angle;

    // Sine over the full turn from the quarter table
    // Bit 6 mirrors the index, bit 7 negates the result
    function automatic trig_t fold_sine(input angle_t a);
        logic [6:0] idx;
        trig_t      mag;
        if (a[6]) begin
            idx = 7'd64 - {1'b0, a[5:0]};
        end else begin
            idx = {1'b0, a[5:0]};
        end
        mag = QUARTER_SINE[idx];
        return a[7] ? -mag : mag;
    endfunction

    // Cosine is the sine a quarter turn ahead
    assign cos_angle = angle + 8'd64;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sin_val <= '0;
            cos_val <= QUARTER_SINE[64];
        end else begin
            sin_val <= fold_sine(angle);
            cos_val <= fold_sine(cos_angle);
        end
    end

    ////////////////////
    // Range check
    ////////////////////

    // Negation of a table entry must stay within full scale
    assert property (@(posedge clk) disable iff (reset)
                     (sin_val <= 16'sh3fff) && (sin_val >= -16'sh3fff) &&
                     (cos_val <= 16'sh3fff) && (cos_val >= -16'sh3fff))
        else $error("trig output exceeds full scale");

endmodule

//--- source/orbit_scaler.sv
`timescale 1ns/10ps

module orbit_scaler #(
    parameter orbit_pkg::coord_t RESET_POS = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  orbit_pkg::trig_t   trig,
    input  orbit_pkg::radius_t radius,
    input  orbit_pkg::coord_t  center,
    output orbit_pkg::coord_t  pos
);
    import orbit_pkg::*;

    logic signed [31:0] product;
    logic               prod_valid;

    ////////////////////
    // Stage 1 multiply
    ////////////////////

    // Radius widened with a zero sign bit so the product stays signed
    always_ff @(posedge clk) begin
        product <= trig * $signed({1'b0, radius});
    end

    // Marks the first product after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= 1'b1;
        end
    end

    ////////////////////
    // Stage 2 shift and offset
    ////////////////////

    // Position holds its reset value until a real product arrives
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos <= RESET_POS;
        end else if (prod_valid) begin
            pos <= center + coord_t'(product >>> TRIG_FRAC_BITS);
        end
    end

endmodule

//--- source/hex_display.sv
`timescale 1ns/10ps

module hex_display #(
    parameter int DIGIT_COUNT = 4
) (
    input  orbit_pkg::coord_t           value,
    output logic [DIGIT_COUNT-1:0][6:0] segments
);
    import orbit_pkg::*;

    if ((DIGIT_COUNT < 1) || (DIGIT_COUNT > 8)) begin : g_count_check
        $error("hex_display needs 1 to 8 digits");
    end

    // Digit 0 shows the lowest nibble
    for (genvar i = 0; i < DIGIT_COUNT; i++) begin : g_digit
        assign segments[i] = SEG_GLYPHS[value[4*i +: 4]];
    end

endmodule

//--- source/orbit_top.sv
`timescale 1ns/10ps

module orbit_top #(
    parameter int DIGIT_COUNT = 4
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [apb_map_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic [apb_map_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [apb_map_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    output logic [DIGIT_COUNT-1:0][6:0]            hex
);
    import orbit_pkg::*;

    angle_t  angle;
    radius_t radius;
    coord_t  center_x;
    coord_t  center_y;
    coord_t  pos_x;
    coord_t  pos_y;
    coord_t  disp_value;
    trig_t   sin_val;
    trig_t   cos_val;
    logic    disp_sel;

    ////////////////////
    // Control and registers
    ////////////////////

    orbit_ctrl ctrl_i (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .pos_x    (pos_x),
        .pos_y    (pos_y),
        .angle    (angle),
        .radius   (radius),
        .center_x (center_x),
        .center_y (center_y),
        .disp_sel (disp_sel)
    );

    ////////////////////
    // Datapath
    ////////////////////

    trig_lut lut_i (
        .clk     (clk),
        .reset   (reset),
        .angle   (angle),
        .sin_val (sin_val),
        .cos_val (cos_val)
    );

    // X follows cosine
    orbit_scaler #(
        .RESET_POS (RESET_CENTER_X + coord_t'(RESET_RADIUS))
    ) x_scaler_i (
        .clk    (clk),
        .reset  (reset),
        .trig   (cos_val),
        .radius (radius),
        .center (center_x),
        .pos    (pos_x)
    );

    // Y follows sine
    orbit_scaler #(
        .RESET_POS (RESET_CENTER_Y)
    ) y_scaler_i (
        .clk    (clk),
        .reset  (reset),
        .trig   (sin_val),
        .radius (radius),
        .center (center_y),
        .pos    (pos_y)
    );

    ////////////////////
    // Display
    ////////////////////

    assign disp_value = disp_sel ? pos_y : pos_x;

    hex_display #(
        .DIGIT_COUNT (DIGIT_COUNT)
    ) display_i (
        .value    (disp_value),
        .segments (hex)
    );

endmodule

//--- tb/orbit_tb.sv
`timescale 1ns/10ps

module orbit_tb;
    import orbit_pkg::*;
    import apb_map_pkg::*;

    localparam int DIGIT_COUNT   = 4;
    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int EDGE_POINTS   = 4;
    localparam int RANDOM_POINTS = 12;
    localparam int RUN_TRIALS    = 8;

    // Rough cycle budget per test phase
    localparam int TEST_CYCLES = RESET_CYCLES + 20 + 51 +
                                 (EDGE_POINTS + RANDOM_POINTS) * 21 + RUN_TRIALS * 17;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 3 / 2;

    logic                          clk;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [APB_ADDR_WIDTH-1:0]     paddr;
    logic [APB_DATA_WIDTH-1:0]     pwdata;
    logic [APB_DATA_WIDTH-1:0]     prdata;
    logic                          pready;
    logic                          pslverr;
    logic [DIGIT_COUNT-1:0][6:0]   hex;

    int          check_errors    = 0;
    int          protocol_errors = 0;
    logic [31:0] lcg_state       = 32'h8bea;

    orbit_top #(
        .DIGIT_COUNT (DIGIT_COUNT)
    ) orbit_top_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hex     (hex)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Full-turn sine from the quarter table, one case per quadrant
    function automatic trig_t sine_of(input angle_t a);
        int offset;
        offset = a % 64;
        case (a / 64)
            0:       return QUARTER_SINE[offset];
            1:       return QUARTER_SINE[64 - offset];
            2:       return -QUARTER_SINE[offset];
            default: return -QUARTER_SINE[64 - offset];
        endcase
    endfunction

    // center + (trig * radius) >>> 14, wrapped to 32 bits
    function automatic coord_t expected_pos(input coord_t center, input radius_t radius,
                                            input trig_t t);
        longint prod;
        prod = longint'(t) * longint'(radius);
        prod = prod >>> TRIG_FRAC_BITS;
        return center + prod[31:0];
    endfunction

    ////////////////////
    // Checks and bus tasks
    ////////////////////

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            check_errors++;
            $display("CHECK FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic write_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] data, input logic expect_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        expect_value($sformatf("pready on write to %h", addr), 32'(pready), 32'd1);
        expect_value($sformatf("pslverr on write to %h", addr), 32'(pslverr), 32'(expect_err));
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [APB_ADDR_WIDTH-1:0] addr,
                            output logic [APB_DATA_WIDTH-1:0] data, input logic expect_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        // Read data sampled mid access cycle
        @(negedge clk);
        expect_value($sformatf("pready on read of %h", addr), 32'(pready), 32'd1);
        expect_value($sformatf("pslverr on read of %h", addr), 32'(pslverr), 32'(expect_err));
        data = prdata;
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_read(input logic [APB_ADDR_WIDTH-1:0] addr,
                               input logic [APB_DATA_WIDTH-1:0] exp);
        logic [APB_DATA_WIDTH-1:0] data;
        read_reg(addr, data, 1'b0);
        expect_value($sformatf("read of register %h", addr), data, exp);
    endtask

    // Every digit against the glyph of its nibble
    task automatic expect_hex(input string what, input coord_t shown);
        for (int d = 0; d < DIGIT_COUNT; d++) begin
            expect_value($sformatf("hex digit %0d %s", d, what),
                         32'(hex[d]), 32'(SEG_GLYPHS[shown[4*d +: 4]]));
        end
    endtask

    // Both display selections against the glyph table
    task automatic check_display(input coord_t exp_x, input coord_t exp_y);
        coord_t shown;
        for (int sel = 0; sel < 2; sel++) begin
            write_reg(REG_CTRL, 32'(sel << CTRL_SEL_BIT), 1'b0);
            shown = (sel == 1) ? exp_y : exp_x;
            expect_hex($sformatf("with select %0d", sel), shown);
        end
    endtask

    task automatic check_point(input angle_t a, input radius_t r, input coord_t cx,
                              input coord_t cy);
        angle_t cos_angle;
        coord_t exp_x;
        coord_t exp_y;
        cos_angle = a + 8'd64;
        exp_x     = expected_pos(cx, r, sine_of(cos_angle));
        exp_y     = expected_pos(cy, r, sine_of(a));
        write_reg(REG_RADIUS, 32'(r), 1'b0);
        write_reg(REG_CENTER_X, cx, 1'b0);
        write_reg(REG_CENTER_Y, cy, 1'b0);
        write_reg(REG_ANGLE, 32'(a), 1'b0);
        // Trig stage plus two scaler stages
        idle_cycles(3);
        expect_read(REG_POS_X, exp_x);
        expect_read(REG_POS_Y, exp_y);
        check_display(exp_x, exp_y);
    endtask

    ////////////////////
    // Protocol monitors
    ////////////////////

    assert property (@(posedge clk) disable iff (reset) pready == (psel && penable))
        else begin
            protocol_errors++;
            $display("APB slave drove pready outside the access cycle at %0d ns", $time);
        end

    assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
        else begin
            protocol_errors++;
            $display("APB slave raised pslverr without pready at %0d ns", $time);
        end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [APB_DATA_WIDTH-1:0] data;
        logic [APB_DATA_WIDTH-1:0] first_angle;
        angle_t                    a;
        angle_t                    step;
        angle_t                    exp_angle;
        radius_t                   r;
        coord_t                    cx;
        coord_t                    cy;
        int                        gap;

        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            expect_value("pready in reset", 32'(pready), 32'd0);
            expect_value("pslverr in reset", 32'(pslverr), 32'd0);
        end
        // Display shows the X reset position, center plus radius
        expect_hex("in reset", RESET_CENTER_X + coord_t'(RESET_RADIUS));
        #DRIVE_DELAY;
        reset = 1'b0;

        // Reset defaults
        idle_cycles(3);
        expect_read(REG_CTRL, 32'd0);
        expect_read(REG_STEP, 32'(RESET_STEP));
        expect_read(REG_RADIUS, 32'(RESET_RADIUS));
        expect_read(REG_CENTER_X, RESET_CENTER_X);
        expect_read(REG_CENTER_Y, RESET_CENTER_Y);
        expect_read(REG_ANGLE, 32'd0);
        expect_read(REG_POS_X, expected_pos(RESET_CENTER_X, RESET_RADIUS, sine_of(8'd64)));
        expect_read(REG_POS_Y, expected_pos(RESET_CENTER_Y, RESET_RADIUS, sine_of(8'd0)));

        // Register read back
        step = next_random() >> 24;
        r    = next_random() >> 16;
        cx   = next_random();
        cy   = next_random();
        write_reg(REG_STEP, 32'(step), 1'b0);
        write_reg(REG_RADIUS, 32'(r), 1'b0);
        write_reg(REG_CENTER_X, cx, 1'b0);
        write_reg(REG_CENTER_Y, cy, 1'b0);
        write_reg(REG_CTRL, 32'd2, 1'b0);
        expect_read(REG_STEP, 32'(step));
        expect_read(REG_RADIUS, 32'(r));
        expect_read(REG_CENTER_X, cx);
        expect_read(REG_CENTER_Y, cy);
        expect_read(REG_CTRL, 32'd2);

        // Unmapped offsets and read-only positions
        read_reg(8'h20, data, 1'b1);
        read_reg(8'hFC, data, 1'b1);
        write_reg(8'h0D, 32'hffff_ffff, 1'b1);
        expect_read(REG_CENTER_X, cx);
        write_reg(REG_POS_X, 32'h0, 1'b1);
        write_reg(REG_POS_Y, 32'hffff_ffff, 1'b1);
        expect_read(REG_POS_X, expected_pos(cx, r, sine_of(8'd64)));
        expect_read(REG_POS_Y, expected_pos(cy, r, sine_of(8'd0)));

        // Zero step keeps the angle still while running
        write_reg(REG_STEP, 32'd0, 1'b0);
        write_reg(REG_CTRL, 32'd1, 1'b0);
        write_reg(REG_ANGLE, 32'h33, 1'b1);
        expect_read(REG_ANGLE, 32'd0);
        write_reg(REG_CTRL, 32'd0, 1'b0);

        // Stopped orbit at quadrant edges, then random angles
        for (int i = 0; i < EDGE_POINTS + RANDOM_POINTS; i++) begin
            if (i < EDGE_POINTS) begin
                a = angle_t'(i * 64);
            end else begin
                a = next_random() >> 24;
            end
            r  = next_random() >> 16;
            cx = next_random();
            cy = next_random();
            check_point(a, r, cx, cy);
        end

        // Running accumulator
        for (int t = 0; t < RUN_TRIALS; t++) begin
            step = next_random() >> 24;
            gap  = 2 + (next_random() >> 29);
            write_reg(REG_STEP, 32'(step), 1'b0);
            write_reg(REG_CTRL, 32'd1, 1'b0);
            read_reg(REG_ANGLE, first_angle, 1'b0);
            idle_cycles(gap - 2);
            read_reg(REG_ANGLE, data, 1'b0);
            exp_angle = first_angle[7:0] + gap * step;
            expect_value($sformatf("angle after %0d cycles at step %0d", gap, step),
                         data, 32'(exp_angle));
            write_reg(REG_CTRL, 32'd0, 1'b0);
        end

        $display("errors: %0d value checks, %0d protocol checks", check_errors,
                 protocol_errors);
        if ((check_errors == 0) && (protocol_errors == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

//--- project.f
source/orbit_pkg.sv
source/apb_map_pkg.sv
source/orbit_ctrl.sv
source/trig_lut.sv
source/orbit_scaler.sv
source/hex_display.sv
source/orbit_top.sv
tb/orbit_tb.sv
